//--- Bender.yml
package:
  name: dm_cache

sources:
  - hdl/cache_pkg.sv
  - hdl/cache_line_if.sv
  - hdl/cache_word_mem.sv
  - hdl/cache_meta_mem.sv
  - hdl/cache_line_store.sv
  - hdl/cache_ctrl.sv
  - hdl/cache_top.sv
  - target: test
    files:
      - bench/cache_checker.sv
      - bench/tb_cache.sv

//--- bench/cache_checker.sv
`timescale 1ns/1ps

module cache_checker import cache_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               req,
    input  logic                               we,
    input  logic [addr_width-1:0]              addr,
    input  logic [3:0]                         byte_en,
    input  logic [data_width-1:0]              wdata,
    input  logic                               ready,
    input  logic                               resp,
    input  logic [data_width-1:0]              rdata,
    input  logic                               mem_req,
    input  logic                               mem_we,
    input  logic [addr_width-offset_width-1:0] mem_addr,
    input  logic [block_width-1:0]             mem_wdata,
    input  logic                               exp_miss,
    input  logic                               exp_wb,
    input  ctrl_state_e                        state,
    output int                                 data_errors,
    output int                                 traffic_errors
);

    // processor view of every word
    logic [data_width-1:0] shadow [logic [addr_width-1:0]];
    // tag last loaded into each line
    logic [tag_width-1:0]  line_tag [logic [index_width-1:0]];

    // access in flight
    logic                  busy;
    cache_addr_u           acc_addr;
    logic                  acc_we;
    logic [3:0]            acc_be;
    logic [data_width-1:0] acc_wdata;
    logic                  acc_miss;
    logic                  acc_wb;
    // cycles since the request
    int                    lat;
    // memory traffic of this access
    int                    n_rd;
    int                    n_wr;

    initial begin
        data_errors    = 0;
        traffic_errors = 0;
        busy           = 1'b0;
        lat            = 0;
    end

    function automatic logic [data_width-1:0] expected_word(input logic [addr_width-1:0] a);
        if (shadow.exists(a)) return shadow[a];
        return {2'b00, a} ^ 32'hA5A5_0000;
    endfunction

    ////////////////////////////////////////
    // memory side
    ////////////////////////////////////////

    task automatic check_mem();
        logic [addr_width-offset_width-1:0] want;
        logic [addr_width-1:0]              wa;
        if (!busy) begin
            $display("memory request at %0t with no access in progress", $time);
            traffic_errors++;
        end else if (mem_we) begin
            n_wr++;
            if (n_rd != 0) begin
                $display("writeback at %0t came after the refill", $time);
                traffic_errors++;
            end
            if (!line_tag.exists(acc_addr.parts.index)) begin
                $display("writeback at %0t from a line that was never loaded", $time);
                traffic_errors++;
            end else begin
                want = {line_tag[acc_addr.parts.index], acc_addr.parts.index};
                if (mem_addr !== want) begin
                    $display("Mismatch at %0t: writeback address %h, expected %h (state %s)",
                             $time, mem_addr, want, state.name());
                    traffic_errors++;
                end
            end
            // victim words against the shadow copy
            for (int w = 0; w < block_words; w++) begin
                wa = {mem_addr, w[offset_width-1:0]};
                if (mem_wdata[w*data_width +: data_width] !== expected_word(wa)) begin
                    $display("Mismatch at %0t: writeback word %h is %h, expected %h (state %s)",
                             $time, wa, mem_wdata[w*data_width +: data_width],
                             expected_word(wa), state.name());
                    data_errors++;
                end
            end
        end else begin
            n_rd++;
            want = acc_addr.raw[addr_width-1:offset_width];
            if (mem_addr !== want) begin
                $display("Mismatch at %0t: refill address %h, expected %h (state %s)",
                         $time, mem_addr, want, state.name());
                traffic_errors++;
            end
            line_tag[acc_addr.parts.index] = acc_addr.parts.tag;
        end
    endtask

    ////////////////////////////////////////
    // processor side
    ////////////////////////////////////////

    task automatic check_resp();
        logic [data_width-1:0] word;
        word = expected_word(acc_addr.raw);
        if (!busy) begin
            $display("response at %0t with no access in progress", $time);
            traffic_errors++;
        end else begin
            if (acc_we) begin
                // byte merge into the shadow word
                for (int b = 0; b < 4; b++) begin
                    if (acc_be[b]) word[b*8 +: 8] = acc_wdata[b*8 +: 8];
                end
                shadow[acc_addr.raw] = word;
            end else if (rdata !== word) begin
                $display("Mismatch at %0t: read %h gave %h, expected %h (state %s)",
                         $time, acc_addr.raw, rdata, word, state.name());
                data_errors++;
            end
            // a hit answers two cycles after the request
            if (!acc_miss && lat != 2) begin
                $display("Mismatch at %0t: hit on %h answered after %0d cycles, expected 2",
                         $time, acc_addr.raw, lat);
                traffic_errors++;
            end
            if (n_rd != int'(acc_miss)) begin
                $display("Mismatch at %0t: access %h made %0d refills, expected %0d",
                         $time, acc_addr.raw, n_rd, int'(acc_miss));
                traffic_errors++;
            end
            if (n_wr != int'(acc_wb)) begin
                $display("Mismatch at %0t: access %h made %0d writebacks, expected %0d",
                         $time, acc_addr.raw, n_wr, int'(acc_wb));
                traffic_errors++;
            end
            busy = 1'b0;
        end
    endtask

    // mid cycle sampling sees every strobe once
    always @(negedge clk) begin
        // ready only between accesses
        if (rst_n && ready !== !busy) begin
            $display("Mismatch at %0t: ready is %b, expected %b (state %s)",
                     $time, ready, !busy, state.name());
            traffic_errors++;
        end
        if (busy) lat++;
        if (rst_n && req) begin
            busy      = 1'b1;
            acc_addr  = addr;
            acc_we    = we;
            acc_be    = byte_en;
            acc_wdata = wdata;
            acc_miss  = exp_miss;
            acc_wb    = exp_wb;
            lat       = 0;
            n_rd      = 0;
            n_wr      = 0;
        end
        if (rst_n && mem_req) check_mem();
        if (rst_n && resp) check_resp();
    end

endmodule

//--- bench/tb_cache.sv
`timescale 1ns/1ps

module tb_cache import cache_pkg::*; ();

    // one access of the table
    typedef struct {
        logic                  rst_first;
        logic                  we;
        logic [addr_width-1:0] addr;
        logic [3:0]            byte_en;
        logic [data_width-1:0] wdata;
        logic                  miss;
        logic                  wb;
    } step_t;

    localparam int step_cycles = 30;

    logic                               clk;
    logic                               rst_n;
    logic                               req;
    logic                               we;
    logic [addr_width-1:0]              addr;
    logic [3:0]                         byte_en;
    logic [data_width-1:0]              wdata;
    logic                               ready;
    logic                               resp;
    logic [data_width-1:0]              rdata;
    logic                               mem_req;
    logic                               mem_we;
    logic [addr_width-offset_width-1:0] mem_addr;
    logic [block_width-1:0]             mem_wdata;
    logic                               mem_ack;
    logic [block_width-1:0]             mem_rdata;
    // table expectations handed to the checker
    logic                               exp_miss;
    logic                               exp_wb;
    int                                 data_errors;
    int                                 traffic_errors;

    step_t       steps[$];
    int          cycles = 0;
    int          limit = 0;
    logic [31:0] rng;
    // main memory holding only the blocks written back
    logic [block_width-1:0] blocks [logic [addr_width-offset_width-1:0]];

    cache_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .byte_en   (byte_en),
        .wdata     (wdata),
        .ready     (ready),
        .resp      (resp),
        .rdata     (rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    cache_checker u_check (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .we             (we),
        .addr           (addr),
        .byte_en        (byte_en),
        .wdata          (wdata),
        .ready          (ready),
        .resp           (resp),
        .rdata          (rdata),
        .mem_req        (mem_req),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .exp_miss       (exp_miss),
        .exp_wb         (exp_wb),
        .state          (DUT.u_ctrl.state),
        .data_errors    (data_errors),
        .traffic_errors (traffic_errors)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // xorshift32 step
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // unwritten word reads as its own address xor a pattern
    function automatic logic [block_width-1:0] default_block(
        input logic [addr_width-offset_width-1:0] blk
    );
        logic [block_width-1:0] b;
        logic [31:0]            a;
        for (int w = 0; w < block_words; w++) begin
            a = {2'b00, blk, w[offset_width-1:0]};
            b[w*data_width +: data_width] = a ^ 32'hA5A5_0000;
        end
        return b;
    endfunction

    task automatic add_step(
        input logic                    rst_first,
        input logic                    we_s,
        input logic [tag_width-1:0]    tag,
        input logic [index_width-1:0]  index,
        input logic [offset_width-1:0] offset,
        input logic [3:0]              be,
        input logic [data_width-1:0]   data,
        input logic                    miss,
        input logic                    wb
    );
        step_t s;
        s.rst_first = rst_first;
        s.we        = we_s;
        s.addr      = {tag, index, offset};
        s.byte_en   = be;
        s.wdata     = data;
        s.miss      = miss;
        s.wb        = wb;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // reset, we, tag, index, offset, byte_en, wdata, miss, writeback
        add_step(0, 0, 24'h000012, 4'd0, 2'd0, 4'b0000, 32'h0, 1, 0);
        add_step(0, 0, 24'h000012, 4'd0, 2'd0, 4'b0000, 32'h0, 0, 0);
        add_step(0, 0, 24'h000012, 4'd0, 2'd3, 4'b0000, 32'h0, 0, 0);
        add_step(0, 0, 24'h000012, 4'd1, 2'd1, 4'b0000, 32'h0, 1, 0);
        // partial write hit, then read back
        add_step(0, 1, 24'h000012, 4'd0, 2'd1, 4'b0101, 32'h1122_3344, 0, 0);
        add_step(0, 0, 24'h000012, 4'd0, 2'd1, 4'b0000, 32'h0, 0, 0);
        // dirty victim goes back to memory
        add_step(0, 0, 24'h0a0b0c, 4'd0, 2'd2, 4'b0000, 32'h0, 1, 1);
        add_step(0, 0, 24'h000012, 4'd0, 2'd1, 4'b0000, 32'h0, 1, 0);
        // write miss allocates over an invalid or clean line
        add_step(0, 1, 24'h7f0001, 4'd2, 2'd0, 4'b1111, 32'hDEAD_BEEF, 1, 0);
        add_step(0, 0, 24'h7f0001, 4'd2, 2'd0, 4'b0000, 32'h0, 0, 0);
        add_step(0, 1, 24'h000345, 4'd1, 2'd2, 4'b1100, 32'hCAFE_0000, 1, 0);
        add_step(0, 0, 24'h000345, 4'd1, 2'd2, 4'b0000, 32'h0, 0, 0);
        // write miss over a dirty line
        add_step(0, 1, 24'hffff00, 4'd1, 2'd3, 4'b0010, 32'h0000_9900, 1, 1);
        add_step(0, 0, 24'hffff00, 4'd1, 2'd3, 4'b0000, 32'h0, 0, 0);
        // clean every dirty line before the second reset
        add_step(0, 0, 24'h123456, 4'd2, 2'd1, 4'b0000, 32'h0, 1, 1);
        add_step(0, 0, 24'h123456, 4'd1, 2'd0, 4'b0000, 32'h0, 1, 1);
        // lines present before reset miss again
        add_step(1, 0, 24'h000012, 4'd0, 2'd1, 4'b0000, 32'h0, 1, 0);
        add_step(0, 0, 24'h000012, 4'd0, 2'd1, 4'b0000, 32'h0, 0, 0);
        add_step(0, 0, 24'hffff00, 4'd1, 2'd3, 4'b0000, 32'h0, 1, 0);
        add_step(0, 1, 24'h123456, 4'd2, 2'd1, 4'b1000, 32'h5A00_0000, 1, 0);
        add_step(0, 0, 24'h123456, 4'd2, 2'd1, 4'b0000, 32'h0, 0, 0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // one strobe on req, then wait for the response strobe
    task automatic run_step(input step_t s);
        if (s.rst_first) apply_reset();
        @(negedge clk);
        while (!ready) @(negedge clk);
        @(posedge clk);
        #1;
        req      = 1'b1;
        we       = s.we;
        addr     = s.addr;
        byte_en  = s.byte_en;
        wdata    = s.wdata;
        exp_miss = s.miss;
        exp_wb   = s.wb;
        @(posedge clk);
        #1;
        req = 1'b0;
        @(negedge clk);
        while (!resp) @(negedge clk);
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        rst_n    = 1'b0;
        req      = 1'b0;
        we       = 1'b0;
        addr     = '0;
        byte_en  = '0;
        wdata    = '0;
        exp_miss = 1'b0;
        exp_wb   = 1'b0;
        build_table();
        limit = steps.size() * step_cycles;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (steps[i]) run_step(steps[i]);
        repeat (2) @(posedge clk);
        $display("errors: data %0d, traffic %0d, timeout 0", data_errors, traffic_errors);
        if (data_errors + traffic_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // main memory with random ack delay
    initial begin : memory_model
        logic [addr_width-offset_width-1:0] blk;
        int                                 delay;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        rng       = 32'h8973;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req) begin
                blk = mem_addr;
                if (mem_we) blocks[blk] = mem_wdata;
                rng   = next_random(rng);
                delay = int'(rng % 8) + 1;
                repeat (delay) @(posedge clk);
                #1;
                mem_ack   = 1'b1;
                mem_rdata = blocks.exists(blk) ? blocks[blk] : default_block(blk);
                @(posedge clk);
                #1;
                mem_ack = 1'b0;
            end
        end
    end

    // run limit scaled by table length
    initial begin : watchdog
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the access table did not finish within %0d cycles", limit);
        $display("errors: data %0d, traffic %0d, timeout 1", data_errors, traffic_errors);
        $display("Something failed");
        $finish;
    end

endmodule

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // processor side
    input  logic                                 req,
    input  logic                                 we,
    input  cache_addr_u                          addr,
    input  logic [3:0]                           byte_en,
    input  logic [data_width-1:0]                wdata,
    output logic                                 ready,
    output logic                                 resp,
    output logic [data_width-1:0]                rdata,
    // memory side
    output logic                                 mem_req,
    output logic                                 mem_we,
    output logic [addr_width-offset_width-1:0]   mem_addr,
    output logic [block_width-1:0]               mem_wdata,
    input  logic                                 mem_ack,
    input  logic [block_width-1:0]               mem_rdata,
    // line store
    cache_line_if.ctrl                           line
);

    ctrl_state_e state;
    ctrl_state_e state_d;

    // latched request
    logic                  req_we;
    cache_addr_u           req_addr;
    logic [3:0]            req_be;
    logic [data_width-1:0] req_wdata;

    // block address sent to memory
    cache_addr_u blk_addr;

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb begin
        state_d = state;
        case (state)
            idle:      if (req) state_d = compare;
            compare: begin
                if (line.hit) state_d = respond;
                // only a valid dirty victim goes back to memory
                else if (line.valid && line.dirty) state_d = writeback;
                else state_d = refill;
            end
            writeback: if (mem_ack) state_d = refill;
            // loaded line is checked again in compare
            refill:    if (mem_ack) state_d = compare;
            respond:   state_d = idle;
            default:   state_d = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            mem_req <= 1'b0;
        end else begin
            state   <= state_d;
            // one strobe per memory phase
            mem_req <= (state_d != state) && (state_d inside {writeback, refill});
        end
    end

    // request capture and read data
    always_ff @(posedge clk) begin
        if (ready && req) begin
            req_we    <= we;
            req_addr  <= addr;
            req_be    <= byte_en;
            req_wdata <= wdata;
        end
        if (state == compare && line.hit) rdata <= line.data_out;
    end

    assign ready = (state == idle);
    assign resp  = (state == respond);

    ////////////////////////////////////////
    // line store drive
    ////////////////////////////////////////

    always_comb begin
        // compare in compare, load on the refill ack
        line.enable   = (state == compare) || (state == refill && mem_ack);
        line.cmp      = (state != refill);
        line.write    = (state == compare) ? req_we : (state == refill && mem_ack);
        line.byte_en  = req_be;
        line.valid_in = 1'b1;
        line.tag      = req_addr.parts.tag;
        line.index    = req_addr.parts.index;
        line.word_sel = req_addr.parts.offset;
        line.data_in  = req_wdata;
        line.block_in = mem_rdata;
    end

    ////////////////////////////////////////
    // memory port
    ////////////////////////////////////////

    // victim tag on writeback, request tag on refill
    always_comb begin
        blk_addr = req_addr;
        if (state == writeback) blk_addr.parts.tag = line.tag_out;
    end

    assign mem_addr  = blk_addr.raw[addr_width-1:offset_width];
    assign mem_we    = (state == writeback);
    assign mem_wdata = line.block_wb;

    // processor keeps to one access at a time
    a_req_when_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        req |-> ready
    );

    // no second memory request before the ack
    a_mem_one_out: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req |=> (!mem_req until_with mem_ack)
    );

endmodule

//--- hdl/cache_line_if.sv
`timescale 1ns/1ps

interface cache_line_if import cache_pkg::*; ();

    // access control
    logic                    enable;
    logic                    cmp;
    logic                    write;
    logic [3:0]              byte_en;
    logic                    valid_in;
    // line address and write data
    logic [tag_width-1:0]    tag;
    logic [index_width-1:0]  index;
    logic [offset_width-1:0] word_sel;
    logic [data_width-1:0]   data_in;
    logic [block_width-1:0]  block_in;
    // store results
    logic                    hit;
    logic                    dirty;
    logic                    valid;
    logic [tag_width-1:0]    tag_out;
    logic [data_width-1:0]   data_out;
    logic [block_width-1:0]  block_wb;

    // controller side
    modport ctrl (
        output enable, cmp, write, byte_en, valid_in, tag, index, word_sel, data_in, block_in,
        input  hit, dirty, valid, tag_out, data_out, block_wb
    );

    // line store side
    modport store (
        input  enable, cmp, write, byte_en, valid_in, tag, index, word_sel, data_in, block_in,
        output hit, dirty, valid, tag_out, data_out, block_wb
    );

endinterface

//--- hdl/cache_line_store.sv
`timescale 1ns/1ps

module cache_line_store import cache_pkg::*; (
    input logic         clk,
    input logic         rst_n,
    cache_line_if.store line
);

    // access qualifier
    logic go;
    // tag compare
    logic match;
    logic line_hit;
    // metadata
    logic [tag_width-1:0] tag_q;
    logic                 dirty_bit;
    logic                 valid_bit;
    logic                 tag_we;
    logic                 dirty_we;
    logic                 valid_we;
    logic                 dirty_in;
    // word columns
    logic [3:0]             word_be;
    logic [block_words-1:0] word_we;
    logic [data_width-1:0]  word_in  [block_words];
    logic [data_width-1:0]  word_out [block_words];
    logic [block_width-1:0] block_q;

    assign go = line.enable;

    ////////////////////////////////////////
    // tag match and write decode
    ////////////////////////////////////////

    assign match    = (line.tag == tag_q);
    // stale tags after reset never count
    assign line_hit = match & valid_bit;

    // compare write hit sets dirty and a load clears it
    assign dirty_we = go & line.write & (line_hit | ~line.cmp);
    assign dirty_in = line.cmp;
    // tag and valid only change on a load
    assign tag_we   = go & line.write & ~line.cmp;
    assign valid_we = go & line.write & ~line.cmp;

    // byte enables for a store, full word for a load
    assign word_be = line.cmp ? line.byte_en : 4'b1111;

    cache_meta_mem u_meta (
        .clk       (clk),
        .rst_n     (rst_n),
        .tag_we    (tag_we),
        .dirty_we  (dirty_we),
        .valid_we  (valid_we),
        .index     (line.index),
        .tag_in    (line.tag),
        .dirty_in  (dirty_in),
        .valid_in  (line.valid_in),
        .tag_out   (tag_q),
        .dirty_out (dirty_bit),
        .valid_out (valid_bit)
    );

    ////////////////////////////////////////
    // word columns
    ////////////////////////////////////////

    for (genvar w = 0; w < block_words; w++) begin : g_word
        // a store hits one word and a load fills all
        assign word_we[w] = go & line.write &
                            ((line.cmp & line_hit & (line.word_sel == w)) | ~line.cmp);
        assign word_in[w] = line.cmp ? line.data_in : line.block_in[w*data_width +: data_width];

        cache_word_mem u_word (
            .clk      (clk),
            .rst_n    (rst_n),
            .we       (word_we[w]),
            .byte_en  (word_be),
            .index    (line.index),
            .data_in  (word_in[w]),
            .data_out (word_out[w])
        );

        // a store leaves the other words of the line alone
        a_one_word_store: assert property (
            @(posedge clk) disable iff (!rst_n)
            (go && line.cmp && line.write && line_hit && line.word_sel != w)
                ##1 $stable(line.index) |-> $stable(word_out[w])
        );
    end

    // victim block with word 0 in the low bits
    always_comb begin
        for (int w = 0; w < block_words; w++) begin
            block_q[w*data_width +: data_width] = word_out[w];
        end
    end

    ////////////////////////////////////////
    // results
    ////////////////////////////////////////

    assign line.hit      = line_hit;
    // dirty only matters when a compare misses
    assign line.dirty    = dirty_bit & line.cmp & ~line_hit;
    assign line.valid    = valid_bit;
    assign line.tag_out  = tag_q;
    assign line.data_out = word_out[line.word_sel];
    assign line.block_wb = block_q;

endmodule

//--- hdl/cache_meta_mem.sv
`timescale 1ns/1ps

module cache_meta_mem import cache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   tag_we,
    input  logic                   dirty_we,
    input  logic                   valid_we,
    input  logic [index_width-1:0] index,
    input  logic [tag_width-1:0]   tag_in,
    input  logic                   dirty_in,
    input  logic                   valid_in,
    output logic [tag_width-1:0]   tag_out,
    output logic                   dirty_out,
    output logic                   valid_out
);

    localparam int depth = 1 << index_width;

    // per line state
    logic [tag_width-1:0] tag_mem [depth];
    logic [depth-1:0]     dirty_mem;
    logic [depth-1:0]     valid_mem;

    ////////////////////////////////////////
    // tag and dirty arrays
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (tag_we) tag_mem[index] <= tag_in;
        if (dirty_we) dirty_mem[index] <= dirty_in;
    end

    // valid bits are the only reset state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) valid_mem <= '0;
        else if (valid_we) valid_mem[index] <= valid_in;
    end

    // combinational lookup
    assign tag_out   = tag_mem[index];
    assign dirty_out = dirty_mem[index];
    assign valid_out = valid_mem[index];

    // a line only turns dirty once it holds data
    a_dirty_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dirty_we && dirty_in) |-> valid_mem[index]
    );

endmodule

//--- hdl/cache_pkg.sv
package cache_pkg;

    ////////////////////////////////////////
    // line geometry
    ////////////////////////////////////////

    // word select within a block
    localparam int offset_width = 2;
    // line select
    localparam int index_width  = 4;
    // processor word address
    localparam int addr_width   = 30;
    localparam int tag_width    = addr_width - index_width - offset_width;
    localparam int data_width   = 32;
    localparam int block_words  = 1 << offset_width;
    localparam int block_width  = block_words * data_width;

    // tag / index / offset split of a word address
    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;
    } cache_addr_s;

    // same word seen flat or split into fields
    typedef union packed {
        logic [addr_width-1:0] raw;
        cache_addr_s           parts;
    } cache_addr_u;

    // controller access states
    typedef enum logic [2:0] {idle, compare, writeback, refill, respond} ctrl_state_e;

endpackage

//--- hdl/cache_top.sv
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,
    // processor port
    input  logic                               req,
    input  logic                               we,
    input  logic [addr_width-1:0]              addr,
    input  logic [3:0]                         byte_en,
    input  logic [data_width-1:0]              wdata,
    output logic                               ready,
    output logic                               resp,
    output logic [data_width-1:0]              rdata,
    // block addressed memory port
    output logic                               mem_req,
    output logic                               mem_we,
    output logic [addr_width-offset_width-1:0] mem_addr,
    output logic [block_width-1:0]             mem_wdata,
    input  logic                               mem_ack,
    input  logic [block_width-1:0]             mem_rdata
);

    // controller to line store link
    cache_line_if line_if ();

    ////////////////////////////////////////
    // access control
    ////////////////////////////////////////

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .byte_en   (byte_en),
        .wdata     (wdata),
        .ready     (ready),
        .resp      (resp),
        .rdata     (rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .line      (line_if.ctrl)
    );

    // tag, state and data arrays
    cache_line_store u_store (
        .clk   (clk),
        .rst_n (rst_n),
        .line  (line_if.store)
    );

endmodule

//--- hdl/cache_word_mem.sv
`timescale 1ns/1ps

module cache_word_mem import cache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   we,
    input  logic [3:0]             byte_en,
    input  logic [index_width-1:0] index,
    input  logic [data_width-1:0]  data_in,
    output logic [data_width-1:0]  data_out
);

    localparam int depth = 1 << index_width;

    // one word of every line
    logic [data_width-1:0] mem [depth];

    // write blocked while reset is held
    logic wr_go;

    assign wr_go = we & rst_n;

    ////////////////////////////////////////
    // byte lane writes
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_go) begin
            // only enabled lanes change
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[index][b*8 +: 8] <= data_in[b*8 +: 8];
                end
            end
        end
    end

    // combinational read
    // new data shows up after the edge
    assign data_out = mem[index];

endmodule

//--- tb.f
hdl/cache_pkg.sv
hdl/cache_line_if.sv
hdl/cache_word_mem.sv
hdl/cache_meta_mem.sv
hdl/cache_line_store.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
bench/cache_checker.sv
bench/tb_cache.sv
